// File: verilog/scc_bus_pkg.sv
/*
 * Avalon side definitions of the scan chain manager.
 * Bus widths, address map, command opcodes and the parameter read values.
 */
package scc_bus_pkg;

	localparam int avl_addr_width = 16;
	localparam int avl_data_width = 32;

	// Address map
	localparam logic [2:0] scc_region = 3'b011;   // Top address bits select the manager
	localparam int region_lsb = 13;
	localparam int op_lsb = 10;                   // Command in bits 12:10
	localparam int par_index_bits = 4;            // Setting or parameter index in bits 3:0

	typedef enum logic [2:0] {
		op_cfg_write = 3'b000,
		op_go_dqs = 3'b001,
		op_go_dqs_io = 3'b010,
		op_go_dq = 3'b011,
		op_go_dm = 3'b100,
		op_update = 3'b101,
		op_none = 3'b111     // Any other command
	} scc_op_t;

	// Read-only parameter indices
	typedef enum logic [3:0] {
		par_dqs_in_delay_max = 4'd1,
		par_dqs_en_phase_max = 4'd2,
		par_dqs_en_delay_max = 4'd3,
		par_dqdqs_out_phase_max = 4'd4,
		par_io_out1_delay_max = 4'd6,
		par_io_out2_delay_max = 4'd7,
		par_io_in_delay_max = 4'd8,
		par_dll_chain_length = 4'd9,
		par_delay_per_opa_tap = 4'd10,
		par_dqs_in_reserve = 4'd11,
		par_dqs_out_reserve = 4'd12,
		par_delay_per_dchain_tap = 4'd13,
		par_dq_out_reserve = 4'd14,
		par_dm_out_reserve = 4'd15
	} scc_param_t;

	// Values for a DLL chain of 8 taps
	localparam int dll_chain_length = 8;
	localparam int delay_per_opa_tap = 312;      // ps
	localparam int delay_per_dchain_tap = 25;    // ps
	localparam int dqs_en_phase_max = 7;
	localparam int dqdqs_out_phase_max = 14;
	localparam int dqs_in_reserve = 3;
	localparam int dqs_out_reserve = 3;
	localparam int dq_out_reserve = 0;
	localparam int dm_out_reserve = 0;

endpackage

// File: verilog/scc_chain_pkg.sv
/*
 * Scan chain side definitions of the manager.
 * Word lengths, field positions, delay limits and group counts of the I/O delay chains.
 */
package scc_chain_pkg;

	// Scan word lengths
	localparam int dqs_sdata_bits = 46;   // One DQS group
	localparam int io_sdata_bits = 11;    // One DQ, DM or DQS I/O pin
	localparam int shift_cnt_width = $clog2(dqs_sdata_bits);

	// Delay chain maxima, also visible through parameter reads
	localparam int dqs_in_delay_max = 15;
	localparam int dqs_en_delay_max = 7;
	localparam int io_out1_delay_max = 15;
	localparam int io_out2_delay_max = 7;
	localparam int io_in_delay_max = 15;

	// Group counts, which set the enable bus widths
	localparam int mem_dqs_width = 4;
	localparam int mem_dq_width = 16;
	localparam int mem_dm_width = 2;

	typedef enum logic [3:0] {
		dqs_in_delay = 4'd1,
		dqs_en_delay = 4'd3,
		oct_out1_delay = 4'd6,
		oct_out2_delay = 4'd7,
		io_out1_delay = 4'd8,
		io_out2_delay = 4'd9,
		io_in_delay = 4'd10
	} scc_setting_t;

	// Fields of the DQS word, all other bits are phase or reserved
	localparam int dqs_in_lsb = 0;
	localparam int dqs_in_bits = 4;
	localparam int dqs_en_lsb = 27;
	localparam int dqs_en_bits = 3;
	localparam int oct_out1_lsb = 30;
	localparam int oct_out1_bits = 4;
	localparam int oct_out2_lsb = 34;
	localparam int oct_out2_bits = 3;

	// Fields of the pin word
	localparam int io_out1_lsb = 0;
	localparam int io_out1_bits = 4;
	localparam int io_out2_lsb = 4;
	localparam int io_out2_bits = 3;
	localparam int io_in_lsb = 7;
	localparam int io_in_bits = 4;

	typedef enum logic [1:0] {
		scan_idle,
		scan_load,
		scan_done
	} scan_state_t;

	localparam logic [7:0] ena_broadcast = 8'd255;   // Enables every member of a bus

endpackage

// File: verilog/scc_avl_decode.sv
/*
 * Avalon slave front end of the scan chain manager.
 * Splits writes into setting writes and scan commands, serves parameter reads.
 */
`timescale 1ns/1ps

module scc_avl_decode (
	input  logic avl_clk,
	input  logic avl_reset_n,
	input  logic [scc_bus_pkg::avl_addr_width-1:0] avl_address,
	input  logic avl_write,
	input  logic [scc_bus_pkg::avl_data_width-1:0] avl_writedata,
	input  logic avl_read,
	input  logic scan_done,
	output logic [scc_bus_pkg::avl_data_width-1:0] avl_readdata,
	output logic avl_waitrequest,
	output logic cfg_wr,
	output scc_chain_pkg::scc_setting_t cfg_addr,
	output logic [scc_bus_pkg::avl_data_width-1:0] cfg_data,
	output scc_bus_pkg::scc_op_t go_op
);
	import scc_bus_pkg::*;
	import scc_chain_pkg::*;

	logic sel_scc;
	scc_op_t bus_op;
	scc_op_t go_live;
	scc_param_t bus_par;
	logic go_busy;      // A go or update transfer is waiting
	scc_op_t go_op_q;

	assign sel_scc = (avl_address[region_lsb +: 3] == scc_region);
	assign bus_op = scc_op_t'(avl_address[op_lsb +: 3]);
	assign bus_par = scc_param_t'(avl_address[par_index_bits-1:0]);

	assign cfg_addr = scc_setting_t'(avl_address[par_index_bits-1:0]);
	assign cfg_data = avl_writedata;

	always_comb
	begin
		cfg_wr = 1'b0;
		go_live = op_none;
		if (sel_scc && avl_write)
		begin
			case (bus_op)
				op_cfg_write: cfg_wr = 1'b1;
				op_go_dqs, op_go_dqs_io, op_go_dq, op_go_dm, op_update: go_live = bus_op;
				default: go_live = op_none;
			endcase
		end
	end

	// Command stays latched for the whole transfer
	assign go_op = go_busy ? go_op_q : go_live;
	assign avl_waitrequest = (go_op != op_none) && avl_write && !scan_done;

	always_ff @(posedge avl_clk or negedge avl_reset_n)
	begin
		if (!avl_reset_n)
		begin
			go_busy <= 1'b0;
			go_op_q <= op_none;
		end
		else
		begin
			go_busy <= avl_waitrequest;   // Clears in the cycle that completes the transfer
			if (!go_busy)
				go_op_q <= go_live;
		end
	end

	// Parameter reads, combinational and never stalled
	always_comb
	begin
		avl_readdata = '0;
		if (sel_scc && avl_read)
		begin
			case (bus_par)
				par_dqs_in_delay_max: avl_readdata = avl_data_width'(dqs_in_delay_max);
				par_dqs_en_phase_max: avl_readdata = avl_data_width'(dqs_en_phase_max);
				par_dqs_en_delay_max: avl_readdata = avl_data_width'(dqs_en_delay_max);
				par_dqdqs_out_phase_max: avl_readdata = avl_data_width'(dqdqs_out_phase_max);
				par_io_out1_delay_max: avl_readdata = avl_data_width'(io_out1_delay_max);
				par_io_out2_delay_max: avl_readdata = avl_data_width'(io_out2_delay_max);
				par_io_in_delay_max: avl_readdata = avl_data_width'(io_in_delay_max);
				par_dll_chain_length: avl_readdata = avl_data_width'(dll_chain_length);
				par_delay_per_opa_tap: avl_readdata = avl_data_width'(delay_per_opa_tap);
				par_dqs_in_reserve: avl_readdata = avl_data_width'(dqs_in_reserve);
				par_dqs_out_reserve: avl_readdata = avl_data_width'(dqs_out_reserve);
				par_delay_per_dchain_tap: avl_readdata = avl_data_width'(delay_per_dchain_tap);
				par_dq_out_reserve: avl_readdata = avl_data_width'(dq_out_reserve);
				par_dm_out_reserve: avl_readdata = avl_data_width'(dm_out_reserve);
				default: avl_readdata = '0;   // Index 0 and 5 are unused
			endcase
		end
	end

endmodule

// File: verilog/scc_cfg_regs.sv
/*
 * Shadow copies of the DQS group word and the pin word.
 * Setting writes update one delay field, the scan engine reads the assembled words.
 */
`timescale 1ns/1ps

module scc_cfg_regs (
	input  logic avl_clk,
	input  logic avl_reset_n,
	input  logic cfg_wr,
	input  scc_chain_pkg::scc_setting_t cfg_addr,
	input  logic [scc_bus_pkg::avl_data_width-1:0] cfg_data,
	output logic [scc_chain_pkg::dqs_sdata_bits-1:0] dqs_cfg,
	output logic [scc_chain_pkg::io_sdata_bits-1:0] io_cfg
);
	import scc_chain_pkg::*;

	// DQS group delays
	logic [dqs_in_bits-1:0] dqs_in_q;
	logic [dqs_en_bits-1:0] dqs_en_q;
	logic [oct_out1_bits-1:0] oct_out1_q;
	logic [oct_out2_bits-1:0] oct_out2_q;

	// Pin delays
	logic [io_out1_bits-1:0] io_out1_q;
	logic [io_out2_bits-1:0] io_out2_q;
	logic [io_in_bits-1:0] io_in_q;

	always_ff @(posedge avl_clk or negedge avl_reset_n)
	begin
		if (!avl_reset_n)
		begin
			dqs_in_q <= '0;
			dqs_en_q <= '0;
			oct_out1_q <= '0;
			oct_out2_q <= '0;
			io_out1_q <= '0;
			io_out2_q <= '0;
			io_in_q <= '0;
		end
		else if (cfg_wr)
		begin
			case (cfg_addr)
				dqs_in_delay: dqs_in_q <= cfg_data[dqs_in_bits-1:0];
				dqs_en_delay: dqs_en_q <= cfg_data[dqs_en_bits-1:0];
				oct_out1_delay: oct_out1_q <= cfg_data[oct_out1_bits-1:0];
				oct_out2_delay: oct_out2_q <= cfg_data[oct_out2_bits-1:0];
				io_out1_delay: io_out1_q <= cfg_data[io_out1_bits-1:0];
				io_out2_delay: io_out2_q <= cfg_data[io_out2_bits-1:0];
				io_in_delay: io_in_q <= cfg_data[io_in_bits-1:0];
				default: dqs_in_q <= dqs_in_q;   // Unknown setting, no change
			endcase
		end
	end

	// Phase and reserved positions are tied low
	always_comb
	begin
		dqs_cfg = '0;
		dqs_cfg[dqs_in_lsb +: dqs_in_bits] = dqs_in_q;
		dqs_cfg[dqs_en_lsb +: dqs_en_bits] = dqs_en_q;
		dqs_cfg[oct_out1_lsb +: oct_out1_bits] = oct_out1_q;
		dqs_cfg[oct_out2_lsb +: oct_out2_bits] = oct_out2_q;
	end

	always_comb
	begin
		io_cfg = '0;
		io_cfg[io_out1_lsb +: io_out1_bits] = io_out1_q;
		io_cfg[io_out2_lsb +: io_out2_bits] = io_out2_q;
		io_cfg[io_in_lsb +: io_in_bits] = io_in_q;
	end

endmodule

// File: verilog/scc_scan_engine.sv
/*
 * Serial scan engine. A go command shifts one shadow word out MSB first
 * while the selected enable bus is driven, an update command pulses scc_update.
 */
`timescale 1ns/1ps

module scc_scan_engine (
	input  logic avl_clk,
	input  logic avl_reset_n,
	input  scc_bus_pkg::scc_op_t go_op,
	input  logic [7:0] ena_index,
	input  logic [scc_chain_pkg::dqs_sdata_bits-1:0] dqs_cfg,
	input  logic [scc_chain_pkg::io_sdata_bits-1:0] io_cfg,
	output logic scc_data,
	output logic [scc_chain_pkg::mem_dqs_width-1:0] scc_dqs_ena,
	output logic [scc_chain_pkg::mem_dqs_width-1:0] scc_dqs_io_ena,
	output logic [scc_chain_pkg::mem_dq_width-1:0] scc_dq_ena,
	output logic [scc_chain_pkg::mem_dm_width-1:0] scc_dm_ena,
	output logic scc_update,
	output logic scan_done
);
	import scc_bus_pkg::*;
	import scc_chain_pkg::*;

	scan_state_t state;
	scc_op_t op_q;
	logic [7:0] idx_q;
	logic [shift_cnt_width-1:0] shift_cnt;   // Bits still to send after the current one
	logic [dqs_sdata_bits-1:0] shift_q;

	logic start_shift;
	logic more_bits;
	scc_op_t ena_op;
	logic [7:0] ena_idx;
	logic [mem_dq_width-1:0] ena_pat;
	logic [dqs_sdata_bits-1:0] load_word;
	logic [shift_cnt_width-1:0] load_cnt;

	// One-hot on the index, all ones for broadcast, nothing past the bus width
	function automatic logic [mem_dq_width-1:0] ena_decode(input logic [7:0] idx,
		input int width);
		logic [mem_dq_width-1:0] pat;
		pat = '0;
		if (idx == ena_broadcast)
			pat = '1;
		else if (int'(idx) < width)
			pat[idx[$clog2(mem_dq_width)-1:0]] = 1'b1;
		return pat;
	endfunction

	assign start_shift = (state == scan_idle) &&
		(go_op inside {op_go_dqs, op_go_dqs_io, op_go_dq, op_go_dm});
	assign more_bits = (state == scan_load) && (shift_cnt != '0);
	assign scan_done = (state == scc_chain_pkg::scan_done);   // Port name hides the state label

	// First bit comes from the live command, the rest from the captured one
	assign ena_op = (state == scan_idle) ? go_op : op_q;
	assign ena_idx = (state == scan_idle) ? ena_index : idx_q;

	always_comb
	begin
		if (go_op == op_go_dqs)
		begin
			load_word = dqs_cfg;
			load_cnt = shift_cnt_width'(dqs_sdata_bits - 1);
		end
		else
		begin
			load_word = {io_cfg, {(dqs_sdata_bits - io_sdata_bits){1'b0}}};   // MSB aligned
			load_cnt = shift_cnt_width'(io_sdata_bits - 1);
		end

		case (ena_op)
			op_go_dqs, op_go_dqs_io: ena_pat = ena_decode(ena_idx, mem_dqs_width);
			op_go_dq: ena_pat = ena_decode(ena_idx, mem_dq_width);
			default: ena_pat = ena_decode(ena_idx, mem_dm_width);
		endcase
	end

	always_ff @(posedge avl_clk or negedge avl_reset_n)
	begin
		if (!avl_reset_n)
		begin
			state <= scan_idle;
			op_q <= op_none;
			shift_cnt <= '0;
			scc_data <= 1'b0;
			scc_update <= 1'b0;
		end
		else
		begin
			scc_data <= 1'b0;
			scc_update <= 1'b0;
			case (state)
				scan_idle:
				begin
					if (start_shift)
					begin
						op_q <= go_op;
						shift_cnt <= load_cnt;
						scc_data <= load_word[dqs_sdata_bits-1];
						state <= scan_load;
					end
					else if (go_op == op_update)
					begin
						scc_update <= 1'b1;
						state <= scc_chain_pkg::scan_done;
					end
				end
				scan_load:
				begin
					if (more_bits)
					begin
						shift_cnt <= shift_cnt - 1'b1;
						scc_data <= shift_q[dqs_sdata_bits-1];
					end
					else
						state <= scc_chain_pkg::scan_done;
				end
				default:
					state <= scan_idle;   // Done lasts one cycle
			endcase
		end
	end

	// Word and index, loaded one bit ahead of the output
	always_ff @(posedge avl_clk)
	begin
		if (start_shift)
		begin
			shift_q <= load_word << 1;
			idx_q <= ena_index;
		end
		else if (more_bits)
			shift_q <= shift_q << 1;
	end

	always_ff @(posedge avl_clk or negedge avl_reset_n)
	begin
		if (!avl_reset_n)
		begin
			scc_dqs_ena <= '0;
			scc_dqs_io_ena <= '0;
			scc_dq_ena <= '0;
			scc_dm_ena <= '0;
		end
		else
		begin
			scc_dqs_ena <= '0;
			scc_dqs_io_ena <= '0;
			scc_dq_ena <= '0;
			scc_dm_ena <= '0;
			if (start_shift || more_bits)
			begin
				case (ena_op)
					op_go_dqs: scc_dqs_ena <= ena_pat[mem_dqs_width-1:0];
					op_go_dqs_io: scc_dqs_io_ena <= ena_pat[mem_dqs_width-1:0];
					op_go_dq: scc_dq_ena <= ena_pat[mem_dq_width-1:0];
					default: scc_dm_ena <= ena_pat[mem_dm_width-1:0];
				endcase
			end
		end
	end

endmodule

// File: verilog/scc_mgr_top.sv
/*
 * Scan chain manager of the DDR sequencer, seen by the calibration processor
 * as an Avalon-MM slave and driving the I/O delay chain scan interface.
 */
`timescale 1ns/1ps

module scc_mgr_top (
	input  logic avl_clk,
	input  logic avl_reset_n,
	input  logic [scc_bus_pkg::avl_addr_width-1:0] avl_address,
	input  logic avl_write,
	input  logic [scc_bus_pkg::avl_data_width-1:0] avl_writedata,
	input  logic avl_read,
	output logic [scc_bus_pkg::avl_data_width-1:0] avl_readdata,
	output logic avl_waitrequest,
	output logic scc_data,
	output logic [scc_chain_pkg::mem_dqs_width-1:0] scc_dqs_ena,
	output logic [scc_chain_pkg::mem_dqs_width-1:0] scc_dqs_io_ena,
	output logic [scc_chain_pkg::mem_dq_width-1:0] scc_dq_ena,
	output logic [scc_chain_pkg::mem_dm_width-1:0] scc_dm_ena,
	output logic scc_update
);
	import scc_bus_pkg::*;
	import scc_chain_pkg::*;

	logic cfg_wr;
	scc_setting_t cfg_addr;
	logic [avl_data_width-1:0] cfg_data;
	scc_op_t go_op;
	logic [dqs_sdata_bits-1:0] dqs_cfg;
	logic [io_sdata_bits-1:0] io_cfg;
	logic scan_done;   // Releases the waiting go or update write

	scc_avl_decode u_decode (
		.avl_clk         (avl_clk),
		.avl_reset_n     (avl_reset_n),
		.avl_address     (avl_address),
		.avl_write       (avl_write),
		.avl_writedata   (avl_writedata),
		.avl_read        (avl_read),
		.scan_done       (scan_done),
		.avl_readdata    (avl_readdata),
		.avl_waitrequest (avl_waitrequest),
		.cfg_wr          (cfg_wr),
		.cfg_addr        (cfg_addr),
		.cfg_data        (cfg_data),
		.go_op           (go_op)
	);

	scc_cfg_regs u_cfg_regs (
		.avl_clk     (avl_clk),
		.avl_reset_n (avl_reset_n),
		.cfg_wr      (cfg_wr),
		.cfg_addr    (cfg_addr),
		.cfg_data    (cfg_data),
		.dqs_cfg     (dqs_cfg),
		.io_cfg      (io_cfg)
	);

	scc_scan_engine u_scan_engine (
		.avl_clk        (avl_clk),
		.avl_reset_n    (avl_reset_n),
		.go_op          (go_op),
		.ena_index      (avl_writedata[7:0]),   // Enable index rides on the go write
		.dqs_cfg        (dqs_cfg),
		.io_cfg         (io_cfg),
		.scc_data       (scc_data),
		.scc_dqs_ena    (scc_dqs_ena),
		.scc_dqs_io_ena (scc_dqs_io_ena),
		.scc_dq_ena     (scc_dq_ena),
		.scc_dm_ena     (scc_dm_ena),
		.scc_update     (scc_update),
		.scan_done      (scan_done)
	);

endmodule

// File: tb/scc_mgr_checker.sv
/*
 * Concurrent checks on the Avalon handshake and the scan outputs.
 * Bound into the manager top level.
 */
`timescale 1ns/1ps

module scc_mgr_checker (
	input logic avl_clk,
	input logic avl_reset_n,
	input logic [scc_bus_pkg::avl_addr_width-1:0] avl_address,
	input logic avl_write,
	input logic avl_waitrequest,
	input logic scan_done,
	input logic scc_update,
	input logic [scc_chain_pkg::mem_dqs_width-1:0] scc_dqs_ena,
	input logic [scc_chain_pkg::mem_dqs_width-1:0] scc_dqs_io_ena,
	input logic [scc_chain_pkg::mem_dq_width-1:0] scc_dq_ena,
	input logic [scc_chain_pkg::mem_dm_width-1:0] scc_dm_ena
);
	import scc_bus_pkg::*;

	logic write_seen;   // A write was present since the last completion
	logic go_addr;      // Address holds a go or update command of the manager

	assign go_addr = (avl_address[region_lsb +: 3] == scc_region) &&
		(scc_op_t'(avl_address[op_lsb +: 3]) inside
			{op_go_dqs, op_go_dqs_io, op_go_dq, op_go_dm, op_update});

	always_ff @(posedge avl_clk or negedge avl_reset_n)
	begin
		if (!avl_reset_n)
			write_seen <= 1'b0;
		else if (scan_done)
			write_seen <= 1'b0;
		else if (avl_write)
			write_seen <= 1'b1;
	end

	update_one_cycle: assert property (@(posedge avl_clk) disable iff (!avl_reset_n)
		scc_update |=> !scc_update)
		else $error("scc_update held for more than one cycle");

	one_enable_bus: assert property (@(posedge avl_clk) disable iff (!avl_reset_n)
		$onehot0({|scc_dqs_ena, |scc_dqs_io_ena, |scc_dq_ena, |scc_dm_ena}))
		else $error("more than one enable bus active");

	// Only a held go or update write may be stalled
	wait_only_on_go: assert property (@(posedge avl_clk) disable iff (!avl_reset_n)
		avl_waitrequest |-> avl_write && go_addr)
		else $error("wait-request raised outside a go or update write");

	// Each completion belongs to its own write
	done_per_write: assert property (@(posedge avl_clk) disable iff (!avl_reset_n)
		$rose(scan_done) |-> write_seen)
		else $error("scan_done rose twice without a write in between");

endmodule

bind scc_mgr_top scc_mgr_checker u_checker (
	.avl_clk         (avl_clk),
	.avl_reset_n     (avl_reset_n),
	.avl_address     (avl_address),
	.avl_write       (avl_write),
	.avl_waitrequest (avl_waitrequest),
	.scan_done       (scan_done),
	.scc_update      (scc_update),
	.scc_dqs_ena     (scc_dqs_ena),
	.scc_dqs_io_ena  (scc_dqs_io_ena),
	.scc_dq_ena      (scc_dq_ena),
	.scc_dm_ena      (scc_dm_ena)
);

// File: tb/tb_scc_mgr.sv
/*
 * Table driven testbench of the scan chain manager.
 * Runs parameter reads, setting writes and scan commands, checks the scan side against a local model.
 */
`timescale 1ns/1ps

module tb_scc_mgr;

	localparam int kind_read = 0;
	localparam int kind_cfg = 1;
	localparam int kind_go = 2;
	localparam int kind_update = 3;

	// Parameter read values by index, 0 and 5 are unused
	localparam int param_exp [16] = '{0, 15, 7, 7, 14, 0, 15, 7, 15, 8, 312, 3, 3, 25, 0, 0};

	logic avl_clk;
	logic avl_reset_n;
	logic [15:0] avl_address;
	logic avl_write;
	logic [31:0] avl_writedata;
	logic avl_read;
	logic [31:0] avl_readdata;
	logic avl_waitrequest;
	logic scc_data;
	logic [3:0] scc_dqs_ena;
	logic [3:0] scc_dqs_io_ena;
	logic [15:0] scc_dq_ena;
	logic [1:0] scc_dm_ena;
	logic scc_update;

	int row_kind[$];
	logic [15:0] row_addr[$];
	logic [31:0] row_data[$];
	logic [31:0] row_exp[$];   // Read data, or wait cycles of a write

	logic [45:0] dqs_model;
	logic [10:0] io_model;
	int errors;
	int update_count;
	bit table_ready;

	scc_mgr_top u_dut (
		.avl_clk         (avl_clk),
		.avl_reset_n     (avl_reset_n),
		.avl_address     (avl_address),
		.avl_write       (avl_write),
		.avl_writedata   (avl_writedata),
		.avl_read        (avl_read),
		.avl_readdata    (avl_readdata),
		.avl_waitrequest (avl_waitrequest),
		.scc_data        (scc_data),
		.scc_dqs_ena     (scc_dqs_ena),
		.scc_dqs_io_ena  (scc_dqs_io_ena),
		.scc_dq_ena      (scc_dq_ena),
		.scc_dm_ena      (scc_dm_ena),
		.scc_update      (scc_update)
	);

	initial avl_clk = 1'b0;
	always #10 avl_clk = ~avl_clk;

	always @(negedge avl_clk)
	begin
		if (scc_update)
			update_count = update_count + 1;
	end

	function automatic logic [15:0] reg_addr(input logic [2:0] op, input logic [3:0] idx);
		return {3'b011, op, 6'b000000, idx};
	endfunction

	// One-hot on the index, all ones for 255, nothing past the bus width
	function automatic logic [15:0] expected_enable(input logic [7:0] idx, input int width);
		logic [15:0] pat;
		pat = '0;
		if (idx == 8'd255)
			pat = 16'((32'd1 << width) - 32'd1);
		else if (int'(idx) < width)
			pat[idx[3:0]] = 1'b1;
		return pat;
	endfunction

	task automatic add_row(input int kind, input logic [15:0] addr, input logic [31:0] data,
		input logic [31:0] exp);
		row_kind.push_back(kind);
		row_addr.push_back(addr);
		row_data.push_back(data);
		row_exp.push_back(exp);
	endtask

	task automatic update_model(input logic [3:0] idx, input logic [31:0] data);
		case (idx)
			4'd1: dqs_model[3:0] = data[3:0];
			4'd3: dqs_model[29:27] = data[2:0];
			4'd6: dqs_model[33:30] = data[3:0];
			4'd7: dqs_model[36:34] = data[2:0];
			4'd8: io_model[3:0] = data[3:0];
			4'd9: io_model[6:4] = data[2:0];
			4'd10: io_model[10:7] = data[3:0];
			default: ;   // Unknown setting
		endcase
	endtask

	task automatic build_table();
		// Both words are still zero here
		add_row(kind_go, reg_addr(3'd3, 4'd0), 32'd0, 32'd12);
		add_row(kind_go, reg_addr(3'd1, 4'd0), 32'd1, 32'd47);
		for (int p = 0; p < 16; p++)
			add_row(kind_read, reg_addr(3'd0, 4'(p)), 32'd0, 32'(param_exp[p]));
		add_row(kind_read, 16'h0001, 32'd0, 32'd0);   // Outside the region
		add_row(kind_read, 16'h2009, 32'd0, 32'd0);
		add_row(kind_cfg, reg_addr(3'd0, 4'd8), $urandom & 32'hf, 32'd0);
		add_row(kind_cfg, reg_addr(3'd0, 4'd9), $urandom & 32'h7, 32'd0);
		add_row(kind_cfg, reg_addr(3'd0, 4'd10), $urandom & 32'hf, 32'd0);
		add_row(kind_go, reg_addr(3'd3, 4'd0), 32'd5, 32'd12);
		add_row(kind_go, reg_addr(3'd2, 4'd0), 32'd255, 32'd12);
		add_row(kind_go, reg_addr(3'd4, 4'd0), 32'd1, 32'd12);
		add_row(kind_go, reg_addr(3'd4, 4'd0), 32'd2, 32'd12);   // Past the DM bus
		add_row(kind_go, reg_addr(3'd3, 4'd0), 32'd16, 32'd12);
		add_row(kind_cfg, reg_addr(3'd0, 4'd1), $urandom & 32'hf, 32'd0);
		add_row(kind_cfg, reg_addr(3'd0, 4'd3), $urandom & 32'h7, 32'd0);
		add_row(kind_cfg, reg_addr(3'd0, 4'd6), $urandom & 32'hf, 32'd0);
		add_row(kind_cfg, reg_addr(3'd0, 4'd7), $urandom & 32'h7, 32'd0);
		add_row(kind_cfg, reg_addr(3'd0, 4'd0), 32'hffffffff, 32'd0);
		add_row(kind_cfg, reg_addr(3'd0, 4'd2), 32'hffffffff, 32'd0);
		add_row(kind_cfg, reg_addr(3'd0, 4'd5), 32'hffffffff, 32'd0);
		add_row(kind_cfg, reg_addr(3'd0, 4'd11), 32'hffffffff, 32'd0);
		add_row(kind_cfg, reg_addr(3'd0, 4'd15), 32'hffffffff, 32'd0);
		add_row(kind_go, reg_addr(3'd1, 4'd0), 32'd3, 32'd47);
		add_row(kind_go, reg_addr(3'd1, 4'd0), 32'd255, 32'd47);
		add_row(kind_go, reg_addr(3'd1, 4'd0), 32'd4, 32'd47);
		add_row(kind_update, reg_addr(3'd5, 4'd0), 32'd0, 32'd1);
		add_row(kind_cfg, reg_addr(3'd0, 4'd9), 32'hffffffff, 32'd0);   // Upper bits dropped
		add_row(kind_go, reg_addr(3'd3, 4'd0), 32'd15, 32'd12);
		add_row(kind_update, reg_addr(3'd5, 4'd0), 32'd0, 32'd1);
		add_row(kind_update, reg_addr(3'd5, 4'd0), 32'd0, 32'd1);
	endtask

	task automatic do_read(input logic [15:0] addr, input logic [31:0] exp);
		@(negedge avl_clk);
		avl_address = addr;
		avl_write = 1'b0;
		avl_read = 1'b1;
		#1;
		if (avl_waitrequest !== 1'b0)
		begin
			errors++;
			$display("mismatch at %0t: read of %h raised wait-request", $time, addr);
		end
		if (avl_readdata !== exp)
		begin
			errors++;
			$display("mismatch at %0t: read of %h gave %0d, expected %0d", $time, addr,
				avl_readdata, exp);
		end
		@(posedge avl_clk);
	endtask

	// Holds the write until wait-request drops, sampling scan outputs in mid cycle
	task automatic bus_write(input logic [15:0] addr, input logic [31:0] data,
		input logic [15:0] want_dqs, input logic [15:0] want_io, input logic [15:0] want_dq,
		input logic [15:0] want_dm, output int waits, output logic [63:0] bits);
		waits = 0;
		bits = '0;
		@(negedge avl_clk);
		avl_address = addr;
		avl_writedata = data;
		avl_read = 1'b0;
		avl_write = 1'b1;
		#1;
		while (avl_waitrequest && waits < 100)
		begin
			@(negedge avl_clk);
			waits++;
			if (avl_waitrequest)   // Scan cycle
			begin
				bits = {bits[62:0], scc_data};
				if (16'(scc_dqs_ena) !== want_dqs || 16'(scc_dqs_io_ena) !== want_io ||
					scc_dq_ena !== want_dq || 16'(scc_dm_ena) !== want_dm)
				begin
					errors++;
					$display("mismatch at %0t: enables %h %h %h %h, expected %h %h %h %h",
						$time, scc_dqs_ena, scc_dqs_io_ena, scc_dq_ena, scc_dm_ena,
						want_dqs, want_io, want_dq, want_dm);
				end
			end
		end
		// Enables end with the last scan bit
		if ({scc_dqs_ena, scc_dqs_io_ena, scc_dq_ena, scc_dm_ena} !== '0)
		begin
			errors++;
			$display("mismatch at %0t: enables %h %h %h %h active outside the scan", $time,
				scc_dqs_ena, scc_dqs_io_ena, scc_dq_ena, scc_dm_ena);
		end
		if (avl_waitrequest)
		begin
			errors++;
			$display("The write to %h was never released by wait-request", addr);
		end
		@(posedge avl_clk);
	endtask

	task automatic apply_row(input int i);
		logic [2:0] op;
		logic [7:0] idx;
		logic [15:0] want_dqs;
		logic [15:0] want_io;
		logic [15:0] want_dq;
		logic [15:0] want_dm;
		logic [63:0] want_bits;
		logic [63:0] bits;
		int waits;
		int updates_before;
		int updates_exp;
		op = row_addr[i][12:10];
		idx = row_data[i][7:0];
		if (row_kind[i] == kind_read)
			do_read(row_addr[i], row_exp[i]);
		else
		begin
			want_dqs = (op == 3'd1) ? expected_enable(idx, 4) : 16'd0;
			want_io = (op == 3'd2) ? expected_enable(idx, 4) : 16'd0;
			want_dq = (op == 3'd3) ? expected_enable(idx, 16) : 16'd0;
			want_dm = (op == 3'd4) ? expected_enable(idx, 2) : 16'd0;
			want_bits = (op == 3'd1) ? 64'(dqs_model) : 64'(io_model);
			if (row_kind[i] == kind_cfg)
				update_model(row_addr[i][3:0], row_data[i]);
			updates_before = update_count;
			updates_exp = updates_before + ((row_kind[i] == kind_update) ? 1 : 0);
			bus_write(row_addr[i], row_data[i], want_dqs, want_io, want_dq, want_dm, waits, bits);
			if (waits != int'(row_exp[i]))
			begin
				errors++;
				$display("mismatch at %0t: row %0d waited %0d cycles, expected %0d", $time, i,
					waits, row_exp[i]);
			end
			if (row_kind[i] == kind_go && bits !== want_bits)
			begin
				errors++;
				$display("mismatch at %0t: row %0d shifted %h, expected %h", $time, i, bits,
					want_bits);
			end
			if (update_count != updates_exp)
			begin
				errors++;
				$display("mismatch at %0t: row %0d saw %0d update pulses, expected %0d", $time,
					i, update_count - updates_before, updates_exp - updates_before);
			end
		end
	endtask

	initial
	begin
		void'($urandom(97124));
		avl_reset_n = 1'b0;
		avl_address = '0;
		avl_write = 1'b0;
		avl_writedata = '0;
		avl_read = 1'b0;
		errors = 0;
		update_count = 0;
		dqs_model = '0;
		io_model = '0;
		build_table();
		table_ready = 1'b1;
		repeat (16) @(negedge avl_clk);
		avl_reset_n = 1'b1;
		repeat (2) @(negedge avl_clk);
		if ({avl_waitrequest, scc_data, scc_update, scc_dqs_ena, scc_dqs_io_ena, scc_dq_ena,
			scc_dm_ena} !== '0)
		begin
			errors++;
			$display("mismatch at %0t: scan outputs or wait-request not low after reset", $time);
		end
		for (int i = 0; i < row_kind.size(); i++)
			apply_row(i);
		@(negedge avl_clk);
		avl_write = 1'b0;
		avl_read = 1'b0;
		repeat (4) @(negedge avl_clk);
		$display("%0d rows applied, %0d errors", row_kind.size(), errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// Watchdog, 50 cycles per row plus margin for reset
	initial
	begin
		wait (table_ready);
		repeat (row_kind.size() * 50 + 100) @(posedge avl_clk);
		$display("Timeout, the table did not finish in the allowed number of cycles");
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: sources.f
verilog/scc_bus_pkg.sv
verilog/scc_chain_pkg.sv
verilog/scc_avl_decode.sv
verilog/scc_cfg_regs.sv
verilog/scc_scan_engine.sv
verilog/scc_mgr_top.sv
tb/scc_mgr_checker.sv
tb/tb_scc_mgr.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the scan chain manager testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary -sv --assert -Wno-fatal --top-module tb_scc_mgr -f sources.f

out=$(./obj_dir/Vtb_scc_mgr 2>&1) || { echo "$out"; echo "simulation exited with an error"; exit 1; }
echo "$out"

if echo "$out" | grep -q "ALL CHECKS PASSED"; then
	exit 0
else
	exit 1
fi
